// File: design/cpu_decode_pkg.sv
package cpu_decode_pkg;

   localparam int NUM_REGS      = 8;
   localparam int INST_DEPTH    = 4;    // Buffer entries and fetch credits
   localparam int ISSUE_CREDITS = 2;
   localparam int PEND_W        = 3;
   localparam int BUF_PTR_W     = $clog2(INST_DEPTH);
   localparam int ISSUE_CNT_W   = $clog2(ISSUE_CREDITS + 1);

   typedef logic [15:0] data_t;
   typedef logic [2:0]  reg_adr_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [2:0]  jump_kind_t;
   typedef logic [1:0]  src_a_sel_t;
   typedef logic [1:0]  src_b_sel_t;
   typedef logic [1:0]  wb_sel_t;

   localparam logic [1:0] OP_LD  = 2'd0;
   localparam logic [1:0] OP_ST  = 2'd1;
   localparam logic [1:0] OP_IMM = 2'd2;    // Immediate and branch family
   localparam logic [1:0] OP_REG = 2'd3;

   localparam alu_op_t ALU_ADD  = 4'd0;
   localparam alu_op_t ALU_CMP  = 4'd5;
   localparam alu_op_t ALU_NONE = 4'd15;

   localparam jump_kind_t JUMP_NONE   = 3'd0;
   localparam jump_kind_t JUMP_ALWAYS = 3'd1;
   localparam jump_kind_t JUMP_EQ     = 3'd2;
   localparam jump_kind_t JUMP_LT     = 3'd3;
   localparam jump_kind_t JUMP_LE     = 3'd4;
   localparam jump_kind_t JUMP_NE     = 3'd5;

   localparam src_a_sel_t SRC_A_REG  = 2'd0;
   localparam src_a_sel_t SRC_A_PC   = 2'd1;
   localparam src_a_sel_t SRC_A_ZERO = 2'd2;

   localparam src_b_sel_t SRC_B_REG  = 2'd0;
   localparam src_b_sel_t SRC_B_D4   = 2'd1;    // Shift amount
   localparam src_b_sel_t SRC_B_SEXT = 2'd2;
   localparam src_b_sel_t SRC_B_ZEXT = 2'd3;

   localparam wb_sel_t WB_ALU = 2'd0;
   localparam wb_sel_t WB_RET = 2'd2;    // Return address
   localparam wb_sel_t WB_IMM = 2'd3;

   // Same 16 bits seen as immediate format or register format
   typedef union packed {
      struct packed {
         logic [1:0] op;
         reg_adr_t   ra;
         reg_adr_t   rb;
         logic [7:0] disp;
      } imm_fmt;
      struct packed {
         logic [1:0] op;
         reg_adr_t   rs;
         reg_adr_t   rd;
         logic [3:0] ty;
         logic [3:0] d4;
      } reg_fmt;
   } inst_t;

endpackage

// File: design/issue_if.sv
`timescale 1ns/1ps

interface issue_if import cpu_decode_pkg::*; ();

   logic       valid;
   alu_op_t    alu_op;
   src_a_sel_t src_a_sel;
   src_b_sel_t src_b_sel;
   wb_sel_t    wb_sel;
   logic       reg_write;
   reg_adr_t   dest;
   logic       mem_read;
   logic       mem_write;
   logic       out_en;
   logic       halt;
   logic       lock;
   logic       unlock;
   jump_kind_t jump_kind;
   data_t      ra_data;
   data_t      rb_data;
   data_t      imm;

   modport source (output valid, alu_op, src_a_sel, src_b_sel, wb_sel, reg_write, dest,
                   mem_read, mem_write, out_en, halt, lock, unlock, jump_kind,
                   ra_data, rb_data, imm);

   modport sink (input valid, alu_op, src_a_sel, src_b_sel, wb_sel, reg_write, dest,
                 mem_read, mem_write, out_en, halt, lock, unlock, jump_kind,
                 ra_data, rb_data, imm);

endinterface

// File: design/controller.sv
`timescale 1ns/1ps

module controller import cpu_decode_pkg::*; (
   input  logic       flushed,
   input  inst_t      inst,
   output alu_op_t    alu_op,
   output src_a_sel_t src_a_sel,
   output src_b_sel_t src_b_sel,
   output wb_sel_t    wb_sel,
   output logic       reg_write,
   output logic       dest_is_ra,
   output logic       mem_read,
   output logic       mem_write,
   output logic       out_en,
   output logic       is_halt,
   output logic       lock_en,
   output logic       unlock_en,
   output jump_kind_t jump_kind,
   output logic       use_ra,
   output logic       use_rb,
   output reg_adr_t   ra,
   output reg_adr_t   rb
);

   // Register format rs/rd sit at the same bit positions
   assign ra = inst.imm_fmt.ra;
   assign rb = inst.imm_fmt.rb;

   always_comb begin
      alu_op     = ALU_NONE;
      src_a_sel  = SRC_A_REG;
      src_b_sel  = SRC_B_REG;
      wb_sel     = WB_ALU;
      reg_write  = 1'b0;
      dest_is_ra = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      out_en     = 1'b0;
      is_halt    = 1'b0;
      lock_en    = 1'b0;
      unlock_en  = 1'b0;
      jump_kind  = JUMP_NONE;
      use_ra     = 1'b0;
      use_rb     = 1'b0;

      if (!flushed) begin
         case (inst.imm_fmt.op)
            OP_LD: begin
               use_rb     = 1'b1;    // Base register
               reg_write  = 1'b1;
               dest_is_ra = 1'b1;
               src_b_sel  = SRC_B_SEXT;
               mem_read   = 1'b1;
            end
            OP_ST: begin
               use_ra    = 1'b1;
               use_rb    = 1'b1;
               mem_write = 1'b1;
               src_b_sel = SRC_B_SEXT;
            end
            OP_IMM: begin
               case (inst.imm_fmt.ra)
                  3'd0: begin    // LI
                     reg_write = 1'b1;
                     wb_sel    = WB_IMM;
                  end
                  3'd1: begin    // ADDI
                     use_rb    = 1'b1;
                     reg_write = 1'b1;
                     alu_op    = ALU_ADD;
                     src_b_sel = SRC_B_SEXT;
                  end
                  3'd2: begin    // CMPI
                     use_rb    = 1'b1;
                     alu_op    = ALU_CMP;
                     src_b_sel = SRC_B_SEXT;
                  end
                  3'd3: begin
                     if (inst.imm_fmt.rb[2]) begin
                        unlock_en = 1'b1;
                     end else begin
                        lock_en = 1'b1;
                     end
                  end
                  3'd4: begin    // B
                     jump_kind = JUMP_ALWAYS;
                     src_a_sel = SRC_A_PC;
                     src_b_sel = SRC_B_SEXT;
                  end
                  3'd5: begin    // BAL
                     jump_kind = JUMP_ALWAYS;
                     src_a_sel = SRC_A_PC;
                     src_b_sel = SRC_B_SEXT;
                     reg_write = 1'b1;
                     wb_sel    = WB_RET;
                  end
                  3'd6: begin    // BR
                     jump_kind = JUMP_ALWAYS;
                     src_b_sel = SRC_B_SEXT;
                  end
                  default: begin
                     // Conditional branches with the condition in rb
                     src_a_sel = SRC_A_PC;
                     src_b_sel = SRC_B_SEXT;
                     case (inst.imm_fmt.rb)
                        3'd0:    jump_kind = JUMP_EQ;
                        3'd1:    jump_kind = JUMP_LT;
                        3'd2:    jump_kind = JUMP_LE;
                        3'd3:    jump_kind = JUMP_NE;
                        default: jump_kind = JUMP_ALWAYS;
                     endcase
                  end
               endcase
            end
            default: begin
               alu_op = inst.reg_fmt.ty;
               case (inst.reg_fmt.ty)
                  4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                     use_ra    = 1'b1;
                     use_rb    = 1'b1;
                     reg_write = 1'b1;
                  end
                  4'd5: begin    // CMP
                     use_ra = 1'b1;
                     use_rb = 1'b1;
                  end
                  4'd6: begin    // MOV
                     use_ra    = 1'b1;
                     src_a_sel = SRC_A_ZERO;
                     reg_write = 1'b1;
                  end
                  4'd8, 4'd9, 4'd10, 4'd11: begin    // Shifts by d4
                     use_rb    = 1'b1;
                     reg_write = 1'b1;
                     src_b_sel = SRC_B_D4;
                  end
                  4'd12: begin
                     reg_write = 1'b1;
                     src_a_sel = SRC_A_ZERO;
                     src_b_sel = SRC_B_ZEXT;
                  end
                  4'd13: begin    // OUT
                     use_ra = 1'b1;
                     out_en = 1'b1;
                  end
                  4'd15: is_halt = 1'b1;
                  default: ;
               endcase
            end
         endcase
      end
   end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_decode_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  reg_adr_t rd_adr_a,
   input  reg_adr_t rd_adr_b,
   output data_t    rd_data_a,
   output data_t    rd_data_b,
   input  logic     wr_en,
   input  reg_adr_t wr_adr,
   input  data_t    wr_data
);

   data_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_adr] <= wr_data;
      end
   end

   // No bypass so readers wait one cycle after write-back
   assign rd_data_a = regs[rd_adr_a];
   assign rd_data_b = regs[rd_adr_b];

endmodule

// File: design/scoreboard.sv
`timescale 1ns/1ps

module scoreboard import cpu_decode_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  reg_adr_t src_a,
   input  logic     use_a,
   input  reg_adr_t src_b,
   input  logic     use_b,
   input  logic     issue_write,
   input  reg_adr_t issue_dest,
   input  logic     retire,
   input  reg_adr_t retire_adr,
   output logic     hazard
);

   logic [PEND_W-1:0]   pend [NUM_REGS];
   logic [NUM_REGS-1:0] inc;
   logic [NUM_REGS-1:0] dec;

   always_comb begin
      inc = '0;
      dec = '0;
      if (issue_write) begin
         inc[issue_dest] = 1'b1;
      end
      if (retire) begin
         dec[retire_adr] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            pend[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_REGS; i++) begin
            if (inc[i] && !dec[i]) begin
               pend[i] <= pend[i] + 1'b1;
            end else if (dec[i] && !inc[i] && pend[i] != '0) begin
               pend[i] <= pend[i] - 1'b1;
            end
         end
      end
   end

   // Full destination count also stalls
   assign hazard = (use_a && pend[src_a] != '0) ||
                   (use_b && pend[src_b] != '0) ||
                   (&pend[issue_dest]);

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_decode_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       flush,
   input  logic       inst_valid,
   input  inst_t      inst,
   output logic [2:0] inst_credit,
   input  logic       issue_credit,
   output reg_adr_t   rf_adr_a,
   output reg_adr_t   rf_adr_b,
   input  data_t      rf_data_a,
   input  data_t      rf_data_b,
   output reg_adr_t   sb_src_a,
   output logic       sb_use_a,
   output reg_adr_t   sb_src_b,
   output logic       sb_use_b,
   output logic       sb_issue_write,
   output reg_adr_t   sb_issue_dest,
   input  logic       hazard,
   output logic       halted,
   issue_if.source    bundle
);

   inst_t                  buf_mem [INST_DEPTH];
   logic [BUF_PTR_W-1:0]   wr_ptr;
   logic [BUF_PTR_W-1:0]   rd_ptr;
   logic [2:0]             occupancy;
   logic [ISSUE_CNT_W-1:0] issue_cnt;
   inst_t                  head;
   logic                   head_valid;
   logic                   accept;
   logic                   fire;
   data_t                  imm;

   alu_op_t    alu_op;
   src_a_sel_t src_a_sel;
   src_b_sel_t src_b_sel;
   wb_sel_t    wb_sel;
   logic       reg_write;
   logic       dest_is_ra;
   logic       mem_read;
   logic       mem_write;
   logic       out_en;
   logic       is_halt;
   logic       lock_en;
   logic       unlock_en;
   jump_kind_t jump_kind;
   logic       use_ra;
   logic       use_rb;
   reg_adr_t   ra;
   reg_adr_t   rb;
   reg_adr_t   dest;

   assign head       = buf_mem[rd_ptr];
   assign head_valid = occupancy != '0;
   assign accept     = inst_valid && !flush;    // Flush wins over acceptance
   assign fire       = head_valid && issue_cnt != '0 && !hazard && !halted && !flush;

   controller ctrl_i (
      .flushed    (flush || !head_valid),
      .inst       (head),
      .alu_op     (alu_op),
      .src_a_sel  (src_a_sel),
      .src_b_sel  (src_b_sel),
      .wb_sel     (wb_sel),
      .reg_write  (reg_write),
      .dest_is_ra (dest_is_ra),
      .mem_read   (mem_read),
      .mem_write  (mem_write),
      .out_en     (out_en),
      .is_halt    (is_halt),
      .lock_en    (lock_en),
      .unlock_en  (unlock_en),
      .jump_kind  (jump_kind),
      .use_ra     (use_ra),
      .use_rb     (use_rb),
      .ra         (ra),
      .rb         (rb)
   );

   assign dest = dest_is_ra ? ra : rb;

   always_comb begin
      case (src_b_sel)
         SRC_B_D4:   imm = {12'b0, head.reg_fmt.d4};
         SRC_B_ZEXT: imm = {8'b0, head.imm_fmt.disp};
         default:    imm = {{8{head.imm_fmt.disp[7]}}, head.imm_fmt.disp};
      endcase
   end

   assign rf_adr_a       = ra;
   assign rf_adr_b       = rb;
   assign sb_src_a       = ra;
   assign sb_use_a       = use_ra;
   assign sb_src_b       = rb;
   assign sb_use_b       = use_rb;
   assign sb_issue_write = fire && reg_write;
   assign sb_issue_dest  = dest;

   // Flush also hands back the credit of a word it refuses
   assign inst_credit = flush ? occupancy + {2'b0, inst_valid} : {2'b0, fire};

   always_ff @(posedge clk) begin
      if (accept) begin
         buf_mem[wr_ptr] <= inst;
      end
   end

   always_ff @(posedge clk) begin
      if (reset || flush) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         occupancy <= '0;
      end else begin
         if (accept) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (fire) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         occupancy <= occupancy + {2'b0, accept} - {2'b0, fire};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_cnt    <= ISSUE_CNT_W'(ISSUE_CREDITS);
         halted       <= 1'b0;
         bundle.valid <= 1'b0;
      end else begin
         issue_cnt    <= issue_cnt + ISSUE_CNT_W'(issue_credit) - ISSUE_CNT_W'(fire);
         bundle.valid <= fire;
         if (fire && is_halt) begin
            halted <= 1'b1;    // Sticky until reset
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fire) begin
         bundle.alu_op    <= alu_op;
         bundle.src_a_sel <= src_a_sel;
         bundle.src_b_sel <= src_b_sel;
         bundle.wb_sel    <= wb_sel;
         bundle.reg_write <= reg_write;
         bundle.dest      <= dest;
         bundle.mem_read  <= mem_read;
         bundle.mem_write <= mem_write;
         bundle.out_en    <= out_en;
         bundle.halt      <= is_halt;
         bundle.lock      <= lock_en;
         bundle.unlock    <= unlock_en;
         bundle.jump_kind <= jump_kind;
         bundle.ra_data   <= rf_data_a;
         bundle.rb_data   <= rf_data_b;
         bundle.imm       <= imm;
      end
   end

endmodule

// File: design/decode_top.sv
`timescale 1ns/1ps

module decode_top import cpu_decode_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       flush,
   input  logic       inst_valid,
   input  inst_t      inst,
   output logic [2:0] inst_credit,
   output logic       issue_valid,
   input  logic       issue_credit,
   output alu_op_t    alu_op,
   output src_a_sel_t src_a_sel,
   output src_b_sel_t src_b_sel,
   output wb_sel_t    wb_sel,
   output logic       reg_write,
   output reg_adr_t   dest,
   output logic       mem_read,
   output logic       mem_write,
   output logic       out_en,
   output logic       halt,
   output logic       lock,
   output logic       unlock,
   output jump_kind_t jump_kind,
   output data_t      ra_data,
   output data_t      rb_data,
   output data_t      imm,
   input  logic       wb_valid,
   input  reg_adr_t   wb_adr,
   input  data_t      wb_data,
   output logic       halted
);

   issue_if  bus ();
   reg_adr_t rf_adr_a;
   reg_adr_t rf_adr_b;
   data_t    rf_data_a;
   data_t    rf_data_b;
   reg_adr_t sb_src_a;
   logic     sb_use_a;
   reg_adr_t sb_src_b;
   logic     sb_use_b;
   logic     sb_issue_write;
   reg_adr_t sb_issue_dest;
   logic     hazard;

   decode_stage stage_i (
      .clk            (clk),
      .reset          (reset),
      .flush          (flush),
      .inst_valid     (inst_valid),
      .inst           (inst),
      .inst_credit    (inst_credit),
      .issue_credit   (issue_credit),
      .rf_adr_a       (rf_adr_a),
      .rf_adr_b       (rf_adr_b),
      .rf_data_a      (rf_data_a),
      .rf_data_b      (rf_data_b),
      .sb_src_a       (sb_src_a),
      .sb_use_a       (sb_use_a),
      .sb_src_b       (sb_src_b),
      .sb_use_b       (sb_use_b),
      .sb_issue_write (sb_issue_write),
      .sb_issue_dest  (sb_issue_dest),
      .hazard         (hazard),
      .halted         (halted),
      .bundle         (bus.source)
   );

   register_file rf_i (
      .clk       (clk),
      .reset     (reset),
      .rd_adr_a  (rf_adr_a),
      .rd_adr_b  (rf_adr_b),
      .rd_data_a (rf_data_a),
      .rd_data_b (rf_data_b),
      .wr_en     (wb_valid),
      .wr_adr    (wb_adr),
      .wr_data   (wb_data)
   );

   scoreboard sb_i (
      .clk         (clk),
      .reset       (reset),
      .src_a       (sb_src_a),
      .use_a       (sb_use_a),
      .src_b       (sb_src_b),
      .use_b       (sb_use_b),
      .issue_write (sb_issue_write),
      .issue_dest  (sb_issue_dest),
      .retire      (wb_valid),
      .retire_adr  (wb_adr),
      .hazard      (hazard)
   );

   assign issue_valid = bus.valid;
   assign alu_op      = bus.alu_op;
   assign src_a_sel   = bus.src_a_sel;
   assign src_b_sel   = bus.src_b_sel;
   assign wb_sel      = bus.wb_sel;
   assign reg_write   = bus.reg_write;
   assign dest        = bus.dest;
   assign mem_read    = bus.mem_read;
   assign mem_write   = bus.mem_write;
   assign out_en      = bus.out_en;
   assign halt        = bus.halt;
   assign lock        = bus.lock;
   assign unlock      = bus.unlock;
   assign jump_kind   = bus.jump_kind;
   assign ra_data     = bus.ra_data;
   assign rb_data     = bus.rb_data;
   assign imm         = bus.imm;

endmodule

// File: sim/decode_tb.sv
`timescale 1ns/1ps

module decode_tb import cpu_decode_pkg::*; ();

   localparam int RESET_CYCLES = 8;
   localparam int WORDS_RANDOM = 300;
   localparam int WORDS_FLUSH  = 300;
   localparam int WORDS_HALT   = 40;
   localparam int HALT_INDEX   = 30;
   localparam int NUM_TESTS    = 3;
   localparam int CYCLE_LIMIT  = 20 * (WORDS_RANDOM + WORDS_FLUSH + WORDS_HALT) +
                                 NUM_TESTS * RESET_CYCLES;
   localparam int QUIET_CYCLES = 8;
   localparam int PEND_FULL    = 2**PEND_W - 1;

   typedef struct packed {
      alu_op_t    alu_op;
      src_a_sel_t src_a_sel;
      src_b_sel_t src_b_sel;
      wb_sel_t    wb_sel;
      logic       reg_write;
      reg_adr_t   dest;
      logic       mem_read;
      logic       mem_write;
      logic       out_en;
      logic       halt;
      logic       lock;
      logic       unlock;
      jump_kind_t jump_kind;
      logic       use_ra;
      logic       use_rb;
      data_t      ra_data;
      data_t      rb_data;
      data_t      imm;
   } exp_t;

   logic       clk;
   logic       reset;
   logic       flush;
   logic       inst_valid;
   inst_t      inst;
   logic [2:0] inst_credit;
   logic       issue_valid;
   logic       issue_credit;
   alu_op_t    alu_op;
   src_a_sel_t src_a_sel;
   src_b_sel_t src_b_sel;
   wb_sel_t    wb_sel;
   logic       reg_write;
   reg_adr_t   dest;
   logic       mem_read;
   logic       mem_write;
   logic       out_en;
   logic       halt;
   logic       lock;
   logic       unlock;
   jump_kind_t jump_kind;
   data_t      ra_data;
   data_t      rb_data;
   data_t      imm;
   logic       wb_valid;
   reg_adr_t   wb_adr;
   data_t      wb_data;
   logic       halted;

   // Reference model state
   logic [15:0] word_q [$];
   int          cred_due [$];
   int          wb_due [$];
   reg_adr_t    wb_dest [$];
   int          pend [NUM_REGS];
   data_t       regs_m [NUM_REGS];
   int          issue_cnt_m;
   logic        halted_m;
   int          fetch_cred;
   int          exec_out;
   exp_t        exp_bundle;
   logic [15:0] exp_word;
   logic        exp_valid;

   logic [31:0] lfsr;
   int          cycles;
   int          errors;
   int          words_left;
   int          words_sent;
   int          words_total;
   int          n_issued;
   int          n_flushed;
   int          quiet;
   int          halt_at;
   logic        use_flush;
   logic        running;
   logic        done;

   decode_top dut_i (
      .clk          (clk),
      .reset        (reset),
      .flush        (flush),
      .inst_valid   (inst_valid),
      .inst         (inst),
      .inst_credit  (inst_credit),
      .issue_valid  (issue_valid),
      .issue_credit (issue_credit),
      .alu_op       (alu_op),
      .src_a_sel    (src_a_sel),
      .src_b_sel    (src_b_sel),
      .wb_sel       (wb_sel),
      .reg_write    (reg_write),
      .dest         (dest),
      .mem_read     (mem_read),
      .mem_write    (mem_write),
      .out_en       (out_en),
      .halt         (halt),
      .lock         (lock),
      .unlock       (unlock),
      .jump_kind    (jump_kind),
      .ra_data      (ra_data),
      .rb_data      (rb_data),
      .imm          (imm),
      .wb_valid     (wb_valid),
      .wb_adr       (wb_adr),
      .wb_data      (wb_data),
      .halted       (halted)
   );

   always #5 clk = ~clk;

   // Galois LFSR stepped once per bit
   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic logic [15:0] next_word();
      logic [15:0] w;
      w = 16'(take_bits(16));
      if (words_sent == halt_at) begin
         w = 16'hC0F0;    // Register family with ty 15
      end else if (w[15:14] == 2'b11 && w[7:4] == 4'hF) begin
         w[7:4] = 4'hE;    // Keep stray halts out of the stream
      end
      return w;
   endfunction

   // Expected execute controls per instruction family
   function automatic exp_t decode_word(inst_t w);
      exp_t       e;
      logic [2:0] sub;
      logic [3:0] ty;
      e = '0;
      e.alu_op = ALU_NONE;
      e.dest = w.imm_fmt.rb;
      sub = w.imm_fmt.ra;
      ty = w.reg_fmt.ty;
      if (w.imm_fmt.op == OP_LD) begin
         e.use_rb = 1'b1;
         e.reg_write = 1'b1;
         e.dest = w.imm_fmt.ra;
         e.mem_read = 1'b1;
         e.src_b_sel = SRC_B_SEXT;
      end else if (w.imm_fmt.op == OP_ST) begin
         e.use_ra = 1'b1;
         e.use_rb = 1'b1;
         e.mem_write = 1'b1;
         e.src_b_sel = SRC_B_SEXT;
      end else if (w.imm_fmt.op == OP_IMM) begin
         e.src_b_sel = (sub == 3'd0 || sub == 3'd3) ? SRC_B_REG : SRC_B_SEXT;
         e.use_rb = sub == 3'd1 || sub == 3'd2;
         e.reg_write = sub == 3'd0 || sub == 3'd1 || sub == 3'd5;
         e.lock = sub == 3'd3 && !w.imm_fmt.rb[2];
         e.unlock = sub == 3'd3 && w.imm_fmt.rb[2];
         if (sub == 3'd0) e.wb_sel = WB_IMM;
         if (sub == 3'd5) e.wb_sel = WB_RET;
         if (sub == 3'd1) e.alu_op = ALU_ADD;
         if (sub == 3'd2) e.alu_op = ALU_CMP;
         if (sub == 3'd4 || sub == 3'd5 || sub == 3'd7) e.src_a_sel = SRC_A_PC;
         if (sub >= 3'd4 && sub <= 3'd6) e.jump_kind = JUMP_ALWAYS;
         if (sub == 3'd7) begin
            e.jump_kind = (w.imm_fmt.rb < 3'd4) ? JUMP_EQ + w.imm_fmt.rb : JUMP_ALWAYS;
         end
      end else begin
         e.alu_op = ty;
         e.use_ra = ty <= 4'd6 || ty == 4'd13;
         e.use_rb = ty <= 4'd5 || (ty >= 4'd8 && ty <= 4'd11);
         e.reg_write = ty <= 4'd4 || ty == 4'd6 || (ty >= 4'd8 && ty <= 4'd12);
         e.out_en = ty == 4'd13;
         e.halt = ty == 4'd15;
         if (ty == 4'd6 || ty == 4'd12) e.src_a_sel = SRC_A_ZERO;
         if (ty >= 4'd8 && ty <= 4'd11) e.src_b_sel = SRC_B_D4;
         if (ty == 4'd12) e.src_b_sel = SRC_B_ZEXT;
      end
      case (e.src_b_sel)
         SRC_B_D4:   e.imm = {12'b0, w.reg_fmt.d4};
         SRC_B_ZEXT: e.imm = {8'b0, w.imm_fmt.disp};
         default:    e.imm = {{8{w.imm_fmt.disp[7]}}, w.imm_fmt.disp};
      endcase
      return e;
   endfunction

   task automatic bundle_check(logic exp_v, exp_t e);
      string msg;
      msg = "";
      if (issue_valid !== exp_v) begin
         $display("Error at %0t: issue_valid %b, expected %b", $time, issue_valid, exp_v);
         errors++;
      end else if (exp_v) begin
         if (alu_op !== e.alu_op) msg = {msg, $sformatf(" alu_op %0d/%0d", alu_op, e.alu_op)};
         if (src_a_sel !== e.src_a_sel) begin
            msg = {msg, $sformatf(" src_a %0d/%0d", src_a_sel, e.src_a_sel)};
         end
         if (src_b_sel !== e.src_b_sel) begin
            msg = {msg, $sformatf(" src_b %0d/%0d", src_b_sel, e.src_b_sel)};
         end
         if (wb_sel !== e.wb_sel) msg = {msg, $sformatf(" wb_sel %0d/%0d", wb_sel, e.wb_sel)};
         if (reg_write !== e.reg_write) msg = {msg, " reg_write"};
         if (reg_write && dest !== e.dest) msg = {msg, $sformatf(" dest %0d/%0d", dest, e.dest)};
         if (mem_read !== e.mem_read) msg = {msg, " mem_read"};
         if (mem_write !== e.mem_write) msg = {msg, " mem_write"};
         if (out_en !== e.out_en) msg = {msg, " out_en"};
         if (halt !== e.halt) msg = {msg, " halt"};
         if (lock !== e.lock) msg = {msg, " lock"};
         if (unlock !== e.unlock) msg = {msg, " unlock"};
         if (jump_kind !== e.jump_kind) begin
            msg = {msg, $sformatf(" jump %0d/%0d", jump_kind, e.jump_kind)};
         end
         if (ra_data !== e.ra_data) msg = {msg, $sformatf(" ra_data %h/%h", ra_data, e.ra_data)};
         if (rb_data !== e.rb_data) msg = {msg, $sformatf(" rb_data %h/%h", rb_data, e.rb_data)};
         if (imm !== e.imm) msg = {msg, $sformatf(" imm %h/%h", imm, e.imm)};
         if (msg != "") begin
            $display("Error at %0t: word %h bundle got/expected%s", $time, exp_word, msg);
            errors++;
         end
      end
   endtask

   task automatic credit_check(logic [2:0] got, logic [2:0] exp);
      if (got !== exp) begin
         $display("Error at %0t: inst_credit %0d, expected %0d", $time, got, exp);
         errors++;
      end
   endtask

   task automatic halted_check(logic got, logic exp);
      if (got !== exp) begin
         $display("Error at %0t: halted %b, expected %b", $time, got, exp);
         errors++;
      end
   endtask

   task automatic model_reset();
      word_q.delete();
      cred_due.delete();
      wb_due.delete();
      wb_dest.delete();
      for (int i = 0; i < NUM_REGS; i++) begin
         pend[i] = 0;
         regs_m[i] = '0;
      end
      issue_cnt_m = ISSUE_CREDITS;
      halted_m = 1'b0;
      fetch_cred = INST_DEPTH;
      exec_out = 0;
      exp_valid = 1'b0;
      n_issued = 0;
      n_flushed = 0;
      quiet = 0;
   endtask

   task automatic end_checks();
      if (halt_at < 0 && n_issued + n_flushed != words_total) begin
         $display("Words lost or duplicated: %0d sent, %0d issued, %0d flushed",
                  words_total, n_issued, n_flushed);
         errors++;
      end
      if (fetch_cred + word_q.size() != INST_DEPTH) begin
         $display("Fetch credits not conserved: %0d held, %0d buffered",
                  fetch_cred, word_q.size());
         errors++;
      end
      if (halt_at >= 0 && !halted_m) begin
         $display("The halt instruction never issued");
         errors++;
      end
   endtask

   always @(posedge clk) begin : model
      exp_t        head;
      reg_adr_t    ra_m;
      reg_adr_t    rb_m;
      logic        hazard_m;
      logic        fire_m;
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout: the run went past %0d cycles", CYCLE_LIMIT);
         $display("Test FAILED");
         $finish;
      end else if (reset) begin
         model_reset();
      end else if (running) begin
         bundle_check(exp_valid, exp_bundle);
         halted_check(halted, halted_m);
         if (exp_valid) begin
            n_issued++;
            exec_out++;
            cred_due.push_back(cycles + 1 + int'(take_bits(2)));
            if (exp_bundle.reg_write) begin
               wb_due.push_back(cycles + 1 + int'(take_bits(3)));
               wb_dest.push_back(exp_bundle.dest);
            end
         end
         if (issue_credit) exec_out--;
         if (exec_out > ISSUE_CREDITS) begin
            $display("More issues outstanding than execute credits at %0t", $time);
            errors++;
         end

         fire_m = 1'b0;
         head = '0;
         ra_m = '0;
         rb_m = '0;
         if (word_q.size() > 0) begin
            head = decode_word(word_q[0]);
            ra_m = word_q[0][13:11];
            rb_m = word_q[0][10:8];
            hazard_m = (head.use_ra && pend[ra_m] != 0) || (head.use_rb && pend[rb_m] != 0) ||
                       pend[head.dest] == PEND_FULL;
            fire_m = issue_cnt_m > 0 && !hazard_m && !halted_m && !flush;
         end
         credit_check(inst_credit, flush ? 3'(word_q.size() + inst_valid) : {2'b0, fire_m});
         fetch_cred += inst_credit;
         if (fetch_cred > INST_DEPTH) begin
            $display("Fetch got back more credits than words it sent at %0t", $time);
            errors++;
         end

         if (flush) begin
            n_flushed += word_q.size() + inst_valid;
            word_q.delete();
         end else begin
            if (fire_m) begin
               head.ra_data = regs_m[ra_m];    // Reads see writes of earlier edges
               head.rb_data = regs_m[rb_m];
               exp_bundle = head;
               exp_word = word_q.pop_front();
               if (head.reg_write) pend[head.dest]++;
               if (head.halt) halted_m = 1'b1;
            end
            if (inst_valid) word_q.push_back(inst);
         end
         exp_valid = fire_m;
         if (issue_credit) issue_cnt_m++;
         if (fire_m) issue_cnt_m--;
         if (wb_valid) begin
            regs_m[wb_adr] = wb_data;
            pend[wb_adr]--;
         end

         if ((halted_m || (words_left == 0 && word_q.size() == 0)) && wb_due.size() == 0 &&
             cred_due.size() == 0 && exec_out == 0 && !exp_valid) begin
            quiet++;
         end else begin
            quiet = 0;
         end

         if (quiet == QUIET_CYCLES) begin
            end_checks();
            running = 1'b0;
            done = 1'b1;
            flush <= 1'b0;
            inst_valid <= 1'b0;
            issue_credit <= 1'b0;
            wb_valid <= 1'b0;
         end else begin
            flush <= use_flush && take_bits(4) == 0;
            if (fetch_cred > 0 && words_left > 0 && take_bits(2) != 0) begin
               inst <= next_word();
               inst_valid <= 1'b1;
               fetch_cred--;
               words_left--;
               words_sent++;
            end else begin
               inst_valid <= 1'b0;
            end
            if (cred_due.size() > 0 && cred_due[0] <= cycles) begin
               cred_due.delete(0);
               issue_credit <= 1'b1;
            end else begin
               issue_credit <= 1'b0;
            end
            if (wb_due.size() > 0 && wb_due[0] <= cycles) begin
               wb_due.delete(0);
               wb_adr <= wb_dest.pop_front();
               wb_data <= data_t'(take_bits(16));
               wb_valid <= 1'b1;
            end else begin
               wb_valid <= 1'b0;
            end
         end
      end
   end

   task automatic run_test(string name, int n, logic with_flush, int halt_idx);
      int errors_before;
      errors_before = errors;
      words_total = n;
      words_left = n;
      words_sent = 0;
      use_flush = with_flush;
      halt_at = halt_idx;
      done = 1'b0;
      @(posedge clk);
      reset <= 1'b1;
      flush <= 1'b0;
      inst_valid <= 1'b0;
      issue_credit <= 1'b0;
      wb_valid <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      running = 1'b1;
      while (!done) @(posedge clk);
      $display("%s: %0d words sent, %0d issued, %0d flushed, %0d errors", name,
               words_sent, n_issued, n_flushed, errors - errors_before);
   endtask

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      flush = 1'b0;
      inst_valid = 1'b0;
      inst = '0;
      issue_credit = 1'b0;
      wb_valid = 1'b0;
      wb_adr = '0;
      wb_data = '0;
      lfsr = 32'hfd32;
      cycles = 0;
      errors = 0;
      running = 1'b0;
      done = 1'b0;
      halt_at = -1;
      use_flush = 1'b0;
      run_test("random stream", WORDS_RANDOM, 1'b0, -1);
      run_test("flush", WORDS_FLUSH, 1'b1, -1);
      run_test("halt", WORDS_HALT, 1'b0, HALT_INDEX);
      $display("Tests run: %0d, errors: %0d", NUM_TESTS, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: tb.f
design/cpu_decode_pkg.sv
design/issue_if.sv
design/controller.sv
design/register_file.sv
design/scoreboard.sv
design/decode_stage.sv
design/decode_top.sv
sim/decode_tb.sv
